//--- design/rv_pkg.sv
/* Shared types for the RV32I integer datapath. Loads, stores, CSRs and
   system ops are not decoded and retire as illegal. */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcodes handled by the core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [2:0] {TYPE_R, TYPE_I, TYPE_B, TYPE_U, TYPE_J, TYPE_N} inst_type_e;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LINK} wb_sel_e; // link = pc + 4

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // branch offset is scattered over both ends of the word
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;     // raw U bits, J bits are shuffled
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } uj_fmt_t;

    typedef union packed {
        r_fmt_t  r_fmt;
        i_fmt_t  i_fmt;
        b_fmt_t  b_fmt;
        uj_fmt_t uj_fmt;
    } inst_u;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [2:0]            funct3;   // branch condition
        logic [XLEN-1:0]       imm;
        inst_type_e            inst_type;
        alu_op_e               alu_op;
        logic                  a_sel_pc;
        logic                  a_zero;
        logic                  b_imm;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        wb_sel_e               wb_sel;
        logic                  illegal;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       next_pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic [XLEN-1:0]       wdata;
        logic                  illegal;
    } retire_t;

endpackage

//--- design/inst_decoder.sv
/* Purely combinational decode. Unknown opcodes flag illegal and leave
   wb_sel at none, so they never write a register. */
`timescale 1ns/1ns

module inst_decoder (
    input  rv_pkg::inst_u   inst,
    output rv_pkg::decode_t dec
);

    always_comb begin
        dec           = '0;
        dec.rd        = inst.r_fmt.rd;
        dec.rs1       = inst.r_fmt.rs1;
        dec.rs2       = inst.r_fmt.rs2;
        dec.funct3    = inst.r_fmt.funct3;
        dec.inst_type = rv_pkg::TYPE_N;
        dec.alu_op    = rv_pkg::ADD;
        dec.wb_sel    = rv_pkg::WB_NONE;

        // classify and set operand / control selects
        case (inst.r_fmt.opcode)
            rv_pkg::OP_REG: begin
                dec.inst_type = rv_pkg::TYPE_R;
                dec.wb_sel    = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_IMM: begin
                dec.inst_type = rv_pkg::TYPE_I;
                dec.b_imm     = 1'b1;
                dec.wb_sel    = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_LUI: begin
                dec.inst_type = rv_pkg::TYPE_U;
                dec.a_zero    = 1'b1;      // 0 + imm
                dec.b_imm     = 1'b1;
                dec.wb_sel    = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_AUIPC: begin
                dec.inst_type = rv_pkg::TYPE_U;
                dec.a_sel_pc  = 1'b1;      // pc + imm
                dec.b_imm     = 1'b1;
                dec.wb_sel    = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_BRANCH: begin
                dec.inst_type = rv_pkg::TYPE_B;
                dec.is_branch = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                dec.inst_type = rv_pkg::TYPE_J;
                dec.is_jal    = 1'b1;
                dec.wb_sel    = rv_pkg::WB_LINK;
            end
            rv_pkg::OP_JALR: begin
                dec.inst_type = rv_pkg::TYPE_I;
                dec.is_jalr   = 1'b1;
                dec.wb_sel    = rv_pkg::WB_LINK;
            end
            default: dec.illegal = 1'b1;
        endcase

        // sign-extended immediate from the matching view
        case (dec.inst_type)
            rv_pkg::TYPE_I: dec.imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            rv_pkg::TYPE_B: dec.imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12,
                                       inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                                       inst.b_fmt.imm_4_1, 1'b0};
            rv_pkg::TYPE_U: dec.imm = {inst.uj_fmt.imm, 12'h000};
            rv_pkg::TYPE_J: dec.imm = {{11{inst.uj_fmt.imm[19]}}, inst.uj_fmt.imm[19],
                                       inst.uj_fmt.imm[7:0], inst.uj_fmt.imm[8],
                                       inst.uj_fmt.imm[18:9], 1'b0};
            default:        dec.imm = '0;
        endcase

        // alu op only matters for OP and OP-IMM, everything else adds
        if (dec.inst_type == rv_pkg::TYPE_R || inst.r_fmt.opcode == rv_pkg::OP_IMM) begin
            case (inst.r_fmt.funct3)
                3'b000: dec.alu_op = (dec.inst_type == rv_pkg::TYPE_R && inst.r_fmt.funct7[5])
                                     ? rv_pkg::SUB : rv_pkg::ADD;
                3'b001: dec.alu_op = rv_pkg::SLL;
                3'b010: dec.alu_op = rv_pkg::SLT;
                3'b011: dec.alu_op = rv_pkg::SLTU;
                3'b100: dec.alu_op = rv_pkg::XOR;
                3'b101: dec.alu_op = inst.r_fmt.funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                3'b110: dec.alu_op = rv_pkg::OR;
                default: dec.alu_op = rv_pkg::AND;
            endcase
        end
    end

endmodule

//--- design/reg_file.sv
/* 32 x 32-bit integer registers, reads are asynchronous.
   x0 stays zero because writes to it are dropped. */
`timescale 1ns/1ns

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2,
    input  logic [rv_pkg::XLEN-1:0]       wdata,
    output logic [rv_pkg::XLEN-1:0]       rdata1,
    output logic [rv_pkg::XLEN-1:0]       rdata2
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];  // x0 never written, so no read mux needed

    // holds only if every write path really skips x0
    a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

//--- design/alu.sv
/* Integer ALU for OP, OP-IMM, LUI and AUIPC.
   Shift amount is the low 5 bits of operand B. */
`timescale 1ns/1ns

module alu (
    input  rv_pkg::decode_t         dec,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    output logic [rv_pkg::XLEN-1:0] result
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;

    assign op_a  = dec.a_zero ? '0 : (dec.a_sel_pc ? pc : rs1_data);  // lui / auipc
    assign op_b  = dec.b_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ADD:  result = op_a + op_b;
            rv_pkg::SUB:  result = op_a - op_b;
            rv_pkg::SLL:  result = op_a << shamt;
            rv_pkg::SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::XOR:  result = op_a ^ op_b;
            rv_pkg::SRL:  result = op_a >> shamt;
            rv_pkg::SRA:  result = $signed(op_a) >>> shamt;  // sign fill
            rv_pkg::OR:   result = op_a | op_b;
            rv_pkg::AND:  result = op_a & op_b;
            default:      result = op_a + op_b;
        endcase
    end

endmodule

//--- design/branch_unit.sv
/* Branch condition and jump target. funct3 codes 010 and 011
   are not branches and never jump. */
`timescale 1ns/1ns

module branch_unit (
    input  rv_pkg::decode_t         dec,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    output logic                    jump_en,
    output logic [rv_pkg::XLEN-1:0] jump_target
);

    logic [rv_pkg::XLEN-1:0] pc_rel;
    logic [rv_pkg::XLEN-1:0] reg_rel;
    logic                    taken;

    assign pc_rel  = pc + dec.imm;         // branches and jal
    assign reg_rel = rs1_data + dec.imm;   // jalr, lsb dropped below

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_data == rs2_data;
            3'b001:  taken = rs1_data != rs2_data;
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            3'b111:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign jump_en     = dec.is_jal | dec.is_jalr | (dec.is_branch & taken);
    assign jump_target = dec.is_jalr ? {reg_rel[rv_pkg::XLEN-1:1], 1'b0} : pc_rel;

    // pc-relative targets are only even while the pc itself stays even
    a_target_even: assert final (!jump_en || jump_target[0] == 1'b0);

endmodule

//--- design/commit_unit.sv
/* Owns the pc and the retire register. Everything commits on the edge
   that samples inst_valid; there is no stall path. */
`timescale 1ns/1ns

module commit_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  rv_pkg::decode_t         dec,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic [rv_pkg::XLEN-1:0] jump_target,
    input  logic                    jump_en,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    reg_we,
    output logic [rv_pkg::XLEN-1:0] wdata,
    output logic                    retire_valid,
    output rv_pkg::retire_t         retire
);

    logic [rv_pkg::XLEN-1:0] snpc;
    logic [rv_pkg::XLEN-1:0] next_pc;

    assign snpc    = pc + 32'd4;
    assign next_pc = jump_en ? jump_target : snpc;
    assign wdata   = (dec.wb_sel == rv_pkg::WB_LINK) ? snpc : alu_result;
    assign reg_we  = inst_valid && dec.wb_sel != rv_pkg::WB_NONE;  // x0 filtered in reg_file

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= rv_pkg::RESET_PC;
            retire_valid <= 1'b0;
            retire       <= '0;
        end else begin
            retire_valid <= inst_valid;   // one pulse per instruction
            if (inst_valid) begin
                pc             <= next_pc;
                retire.pc      <= pc;
                retire.next_pc <= next_pc;
                retire.rd      <= dec.rd;
                retire.reg_we  <= reg_we;
                retire.wdata   <= wdata;
                retire.illegal <= dec.illegal;
            end
        end
    end

    a_retire_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(inst_valid));

endmodule

//--- design/rv_core.sv
/* RV32I integer core top. One instruction per inst_valid strobe,
   retire record appears one cycle later and must always be taken. */
`timescale 1ns/1ns

module rv_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  rv_pkg::inst_u   inst,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);

    rv_pkg::decode_t         dec;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] jump_target;
    logic                    jump_en;
    logic                    reg_we;
    logic [rv_pkg::XLEN-1:0] wdata;

    inst_decoder u_decoder (.inst(inst), .dec(dec));

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .we(reg_we), .waddr(dec.rd), .wdata(wdata),
        .raddr1(dec.rs1), .raddr2(dec.rs2),
        .rdata1(rs1_data), .rdata2(rs2_data)
    );

    alu u_alu (.dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .result(alu_result));

    branch_unit u_branch (
        .dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .jump_en(jump_en), .jump_target(jump_target)
    );

    commit_unit u_commit (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .dec(dec),
        .alu_result(alu_result), .jump_target(jump_target), .jump_en(jump_en),
        .pc(pc), .reg_we(reg_we), .wdata(wdata),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

//--- test/rv_core_tb.sv
/* Runs test/core_cases.mem through rv_core, so run from the project root.
   Stops at the first mismatch. */
`timescale 1ns/1ns

module rv_core_tb;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CASES  = 64;
    localparam int WORDS      = 7;    // hex columns per case line

    logic            clk;
    logic            reset;
    logic            inst_valid;
    rv_pkg::inst_u   inst;
    logic            retire_valid;
    rv_pkg::retire_t retire;

    logic [31:0]     case_words [WORDS*MAX_CASES];
    int              num_cases;
    logic            cases_ready = 1'b0;
    logic            pending;           // a retire is due at the next falling edge
    rv_pkg::retire_t exp_retire;

    rv_core UUT (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .retire_valid(retire_valid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t act);
        compare_field("retire.pc", exp.pc, act.pc);
        compare_field("retire.next_pc", exp.next_pc, act.next_pc);
        compare_field("retire.reg_we", 32'(exp.reg_we), 32'(act.reg_we));
        compare_field("retire.illegal", 32'(exp.illegal), 32'(act.illegal));
        // rd and wdata only carry meaning on a write
        if (exp.reg_we) begin
            compare_field("retire.rd", 32'(exp.rd), 32'(act.rd));
            compare_field("retire.wdata", exp.wdata, act.wdata);
        end
    endtask

    // one falling edge: check what retired, then drive the next word
    task automatic drive_cycle(input logic valid, input rv_pkg::inst_u word,
                               input rv_pkg::retire_t next_exp);
        @(negedge clk);
        check_bit("retire_valid", pending, retire_valid);
        if (pending) begin
            check_retire(exp_retire, retire);
        end
        inst_valid = valid;
        inst       = word;
        pending    = valid;
        exp_retire = next_exp;
    endtask

    task automatic load_cases();
        $readmemh("test/core_cases.mem", case_words);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_words[WORDS*num_cases+1] != 32'hf) begin
            num_cases++;
        end
        if (num_cases == MAX_CASES) begin
            fail_run("case file has no end-of-list line within the case limit");
        end
        cases_ready = 1'b1;
    endtask

    initial begin
        wait (cases_ready === 1'b1);
        #((num_cases * 2 + 20) * CLK_PERIOD);
        fail_run("watchdog expired, retirement stalled before all cases were checked");
    end

    initial begin
        rv_pkg::retire_t next_exp;
        logic [31:0]     exp_pc;
        int              base;

        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pending    = 1'b0;
        exp_retire = '0;
        load_cases();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("retire_valid", 1'b0, retire_valid);
        check_retire('0, retire);
        drive_cycle(1'b0, '0, '0);    // quiet cycle after reset

        exp_pc = rv_pkg::RESET_PC;
        for (int i = 0; i < num_cases; i++) begin
            base = WORDS * i;
            if (case_words[base+1][0]) begin
                drive_cycle(1'b0, '0, '0);
            end
            next_exp         = '0;
            next_exp.pc      = exp_pc;
            next_exp.next_pc = case_words[base+5];
            next_exp.rd      = case_words[base+2][4:0];
            next_exp.reg_we  = case_words[base+3][0];
            next_exp.wdata   = case_words[base+4];
            next_exp.illegal = case_words[base+6][0];
            drive_cycle(1'b1, case_words[base], next_exp);
            exp_pc = case_words[base+5];   // follows taken branches and jumps
        end
        drive_cycle(1'b0, '0, '0);    // last retire
        drive_cycle(1'b0, '0, '0);    // pulse must be gone again

        $display("sim passed");
        $finish;
    end

endmodule

//--- test/core_cases.mem
// inst gap rd reg_we wdata next_pc illegal; gap 1 = idle cycle first, f = end of list
// rd and wdata are only compared when reg_we is 1
ffb00093 0 01 1 fffffffb 80000004 0
00300113 0 02 1 00000003 80000008 0
401101b3 0 03 1 00000008 8000000c 0
0020a233 0 04 1 00000001 80000010 0
0020b2b3 0 05 1 00000000 80000014 0
4010d313 0 06 1 fffffffd 80000018 0
0010d393 0 07 1 7ffffffd 8000001c 0
12345437 0 08 1 12345000 80000020 0
00001497 1 09 1 80001020 80000024 0
00710013 0 00 1 0000000a 80000028 0
00200533 0 0a 1 00000003 8000002c 0
00208463 0 00 0 00000000 80000030 0
00210463 1 00 0 00000000 80000038 0
00211463 0 00 0 00000000 8000003c 0
00209463 0 00 0 00000000 80000044 0
00114463 0 00 0 00000000 80000048 0
0020c463 0 00 0 00000000 80000050 0
0020d463 0 00 0 00000000 80000054 0
00115463 0 00 0 00000000 8000005c 0
0020e463 0 00 0 00000000 80000060 0
00116463 0 00 0 00000000 80000068 0
00117463 0 00 0 00000000 8000006c 0
fe20f8e3 0 00 0 00000000 8000005c 0
010005ef 0 0b 1 80000060 8000006c 0
01148667 0 0c 1 80000070 80001030 0
00012683 1 00 0 00000000 80001034 1
00b60733 0 0e 1 000000d0 80001038 0
403707b3 1 0f 1 000000c8 8000103c 0
00000000 f 00 0 00000000 00000000 0

//--- rv_core.f
design/rv_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/alu.sv
design/branch_unit.sv
design/commit_unit.sv
design/rv_core.sv
test/rv_core_tb.sv

//--- Makefile
SIM      := verilator
TOP      := rv_core_tb
FILELIST := rv_core.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

$(BUILD)/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
